//--- lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// byte address width
`define LSU_ADDR_W 32

// data word width
`define LSU_XLEN 32

// data RAM depth in words
`define LSU_RAM_WORDS 256

// word index width, taken from address bits 9:2
`define LSU_RAM_IDX_W 8

// destination register index width
`define LSU_REG_W 5

`endif

//--- lsu_mem_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_mem_pkg;

    typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;

    typedef logic [`LSU_XLEN-1:0] lsu_word_t;

    // one enable bit per byte lane
    typedef logic [`LSU_XLEN/8-1:0] lsu_bmask_t;

    typedef logic [`LSU_RAM_IDX_W-1:0] lsu_ram_idx_t;

    // byte position inside a word
    typedef logic [1:0] lsu_offset_t;

endpackage

`default_nettype wire

//--- lsu_op_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_op_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } lsu_size_e;

    typedef enum logic [1:0] {
        EXC_NONE           = 2'b00,
        EXC_LOAD_MISALIGN  = 2'b01,
        EXC_STORE_MISALIGN = 2'b10
    } lsu_exc_e;

    typedef logic [`LSU_REG_W-1:0] lsu_reg_t;

    // byte lanes touched by an access
    function automatic lsu_mem_pkg::lsu_bmask_t byte_mask(
        input lsu_size_e size,
        input lsu_mem_pkg::lsu_offset_t offset
    );
        case (size)
            SIZE_WORD: byte_mask = 4'b1111;
            SIZE_HALF: byte_mask = (offset == 2'd3) ? 4'b1000 : (4'b0011 << offset);
            default:   byte_mask = 4'b0001 << offset;
        endcase
    endfunction

    function automatic logic misaligned(
        input lsu_size_e size,
        input lsu_mem_pkg::lsu_offset_t offset
    );
        case (size)
            SIZE_WORD: misaligned = |offset;
            SIZE_HALF: misaligned = offset[0];
            default:   misaligned = 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- lsu_load_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_params.svh"

module lsu_load_pipe (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       load_valid_i,
    input  lsu_mem_pkg::lsu_addr_t     load_base_i,
    input  lsu_mem_pkg::lsu_addr_t     load_imm_i,
    input  lsu_op_pkg::lsu_size_e      load_size_i,
    input  logic                       load_uext_i,
    input  lsu_op_pkg::lsu_reg_t       load_rd_i,
    input  logic                       load_gnt_i,
    input  lsu_mem_pkg::lsu_word_t     ram_rdata_i,
    output logic                       load_req_o,
    output lsu_mem_pkg::lsu_ram_idx_t  load_idx_o,
    output logic                       load_wb_valid_o,
    output lsu_op_pkg::lsu_reg_t       load_wb_rd_o,
    output lsu_mem_pkg::lsu_word_t     load_wb_data_o,
    output lsu_op_pkg::lsu_exc_e       load_wb_exc_o,
    output logic                       load_replay_o
);

    lsu_mem_pkg::lsu_addr_t     s0_addr;
    logic                       s1_valid;
    logic                       s1_misalign;
    lsu_mem_pkg::lsu_addr_t     s1_addr;
    lsu_op_pkg::lsu_size_e      s1_size;
    logic                       s1_uext;
    lsu_op_pkg::lsu_reg_t       s1_rd;
    lsu_mem_pkg::lsu_offset_t   s1_offset;
    lsu_mem_pkg::lsu_bmask_t    s1_bmask;
    lsu_mem_pkg::lsu_offset_t   s2_offset;
    lsu_mem_pkg::lsu_bmask_t    s2_bmask;
    lsu_op_pkg::lsu_size_e      s2_size;
    logic                       s2_uext;
    lsu_mem_pkg::lsu_word_t     lane_mask;
    lsu_mem_pkg::lsu_word_t     shifted;
    lsu_mem_pkg::lsu_word_t     extended;

    // stage 0: agu
    assign s0_addr = load_base_i + load_imm_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= load_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr     <= s0_addr;
        s1_size     <= load_size_i;
        s1_uext     <= load_uext_i;
        s1_rd       <= load_rd_i;
        s1_misalign <= lsu_op_pkg::misaligned(load_size_i, s0_addr[1:0]);
    end

    // stage 1: ram request, misaligned loads never reach the ram
    assign s1_offset  = s1_addr[1:0];
    assign s1_bmask   = lsu_op_pkg::byte_mask(s1_size, s1_offset);
    assign load_req_o = s1_valid & ~s1_misalign;
    assign load_idx_o = s1_addr[`LSU_RAM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            load_wb_valid_o <= 1'b0;
            load_replay_o   <= 1'b0;
            load_wb_exc_o   <= lsu_op_pkg::EXC_NONE;
        end else begin
            load_wb_valid_o <= s1_valid & (s1_misalign | load_gnt_i);
            // lost the port to a store
            load_replay_o   <= load_req_o & ~load_gnt_i;
            load_wb_exc_o   <= (s1_valid & s1_misalign) ? lsu_op_pkg::EXC_LOAD_MISALIGN
                                                        : lsu_op_pkg::EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        load_wb_rd_o <= s1_rd;
        s2_offset    <= s1_offset;
        s2_bmask     <= s1_bmask;
        s2_size      <= s1_size;
        s2_uext      <= s1_uext;
    end

    // stage 2: keep only the addressed lanes, then align to bit 0
    always_comb begin
        for (int i = 0; i < `LSU_XLEN/8; i++) begin
            lane_mask[8*i +: 8] = {8{s2_bmask[i]}};
        end
    end

    assign shifted = (ram_rdata_i & lane_mask) >> {s2_offset, 3'b000};

    always_comb begin
        case (s2_size)
            lsu_op_pkg::SIZE_BYTE: extended = {{24{~s2_uext & shifted[7]}}, shifted[7:0]};
            lsu_op_pkg::SIZE_HALF: extended = {{16{~s2_uext & shifted[15]}}, shifted[15:0]};
            default:               extended = shifted;
        endcase
    end

    assign load_wb_data_o = (load_wb_exc_o != lsu_op_pkg::EXC_NONE) ? '0 : extended;

endmodule

`default_nettype wire

//--- lsu_store_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_params.svh"

module lsu_store_pipe (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       store_valid_i,
    input  lsu_mem_pkg::lsu_addr_t     store_base_i,
    input  lsu_mem_pkg::lsu_addr_t     store_imm_i,
    input  lsu_op_pkg::lsu_size_e      store_size_i,
    input  lsu_mem_pkg::lsu_word_t     store_data_i,
    output logic                       store_req_o,
    output lsu_mem_pkg::lsu_ram_idx_t  store_idx_o,
    output lsu_mem_pkg::lsu_bmask_t    store_bmask_o,
    output lsu_mem_pkg::lsu_word_t     store_wdata_o,
    output logic                       store_wb_valid_o,
    output lsu_op_pkg::lsu_exc_e       store_wb_exc_o
);

    logic                       s1_valid;
    lsu_mem_pkg::lsu_addr_t     s1_addr;
    lsu_op_pkg::lsu_size_e      s1_size;
    lsu_mem_pkg::lsu_word_t     s1_data;
    lsu_mem_pkg::lsu_offset_t   s1_offset;
    logic                       s1_misalign;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= store_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= store_base_i + store_imm_i;
        s1_size <= store_size_i;
        s1_data <= store_data_i;
    end

    assign s1_offset     = s1_addr[1:0];
    assign s1_misalign   = lsu_op_pkg::misaligned(s1_size, s1_offset);
    assign store_bmask_o = lsu_op_pkg::byte_mask(s1_size, s1_offset);
    assign store_idx_o   = s1_addr[`LSU_RAM_IDX_W+1:2];
    assign store_req_o   = s1_valid & ~s1_misalign;

    // copy data into every lane, the mask picks the right one
    always_comb begin
        case (s1_size)
            lsu_op_pkg::SIZE_BYTE: store_wdata_o = {4{s1_data[7:0]}};
            lsu_op_pkg::SIZE_HALF: store_wdata_o = {2{s1_data[15:0]}};
            default:               store_wdata_o = s1_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            store_wb_valid_o <= 1'b0;
            store_wb_exc_o   <= lsu_op_pkg::EXC_NONE;
        end else begin
            store_wb_valid_o <= s1_valid;
            store_wb_exc_o   <= (s1_valid & s1_misalign) ? lsu_op_pkg::EXC_STORE_MISALIGN
                                                         : lsu_op_pkg::EXC_NONE;
        end
    end

endmodule

`default_nettype wire

//--- lsu_mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_mem_arbiter (
    input  logic                       load_req_i,
    input  lsu_mem_pkg::lsu_ram_idx_t  load_idx_i,
    input  logic                       store_req_i,
    input  lsu_mem_pkg::lsu_ram_idx_t  store_idx_i,
    input  lsu_mem_pkg::lsu_bmask_t    store_bmask_i,
    input  lsu_mem_pkg::lsu_word_t     store_wdata_i,
    output logic                       load_gnt_o,
    output logic                       ram_en_o,
    output logic                       ram_we_o,
    output lsu_mem_pkg::lsu_ram_idx_t  ram_idx_o,
    output lsu_mem_pkg::lsu_bmask_t    ram_bmask_o,
    output lsu_mem_pkg::lsu_word_t     ram_wdata_o
);

    // store always wins, it has no way to retry
    assign load_gnt_o = load_req_i & ~store_req_i;

    assign ram_en_o    = store_req_i | load_req_i;
    assign ram_we_o    = store_req_i;
    assign ram_idx_o   = store_req_i ? store_idx_i : load_idx_i;
    assign ram_bmask_o = store_req_i ? store_bmask_i : '0;
    assign ram_wdata_o = store_req_i ? store_wdata_i : '0;

endmodule

`default_nettype wire

//--- lsu_data_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "lsu_params.svh"

module lsu_data_ram (
    input  logic                       clk,
    input  logic                       ram_en_i,
    input  logic                       ram_we_i,
    input  lsu_mem_pkg::lsu_ram_idx_t  ram_idx_i,
    input  lsu_mem_pkg::lsu_bmask_t    ram_bmask_i,
    input  lsu_mem_pkg::lsu_word_t     ram_wdata_i,
    output lsu_mem_pkg::lsu_word_t     ram_rdata_o
);

    lsu_mem_pkg::lsu_word_t mem [`LSU_RAM_WORDS];

    // single port, a write cycle gives no read data
    always_ff @(posedge clk) begin
        if (ram_en_i) begin
            if (ram_we_i) begin
                for (int i = 0; i < `LSU_XLEN/8; i++) begin
                    if (ram_bmask_i[i]) begin
                        mem[ram_idx_i][8*i +: 8] <= ram_wdata_i[8*i +: 8];
                    end
                end
            end else begin
                ram_rdata_o <= mem[ram_idx_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    load_valid_i,
    input  lsu_mem_pkg::lsu_addr_t  load_base_i,
    input  lsu_mem_pkg::lsu_addr_t  load_imm_i,
    input  lsu_op_pkg::lsu_size_e   load_size_i,
    input  logic                    load_uext_i,
    input  lsu_op_pkg::lsu_reg_t    load_rd_i,
    input  logic                    store_valid_i,
    input  lsu_mem_pkg::lsu_addr_t  store_base_i,
    input  lsu_mem_pkg::lsu_addr_t  store_imm_i,
    input  lsu_op_pkg::lsu_size_e   store_size_i,
    input  lsu_mem_pkg::lsu_word_t  store_data_i,
    output logic                    load_wb_valid_o,
    output lsu_op_pkg::lsu_reg_t    load_wb_rd_o,
    output lsu_mem_pkg::lsu_word_t  load_wb_data_o,
    output lsu_op_pkg::lsu_exc_e    load_wb_exc_o,
    output logic                    load_replay_o,
    output logic                    store_wb_valid_o,
    output lsu_op_pkg::lsu_exc_e    store_wb_exc_o
);

    logic                       load_req;
    logic                       load_gnt;
    lsu_mem_pkg::lsu_ram_idx_t  load_idx;
    logic                       store_req;
    lsu_mem_pkg::lsu_ram_idx_t  store_idx;
    lsu_mem_pkg::lsu_bmask_t    store_bmask;
    lsu_mem_pkg::lsu_word_t     store_wdata;
    logic                       ram_en;
    logic                       ram_we;
    lsu_mem_pkg::lsu_ram_idx_t  ram_idx;
    lsu_mem_pkg::lsu_bmask_t    ram_bmask;
    lsu_mem_pkg::lsu_word_t     ram_wdata;
    lsu_mem_pkg::lsu_word_t     ram_rdata;

    lsu_load_pipe u_load_pipe (
        .clk(clk), .reset_i(reset_i),
        .load_valid_i(load_valid_i), .load_base_i(load_base_i), .load_imm_i(load_imm_i),
        .load_size_i(load_size_i), .load_uext_i(load_uext_i), .load_rd_i(load_rd_i),
        .load_gnt_i(load_gnt), .ram_rdata_i(ram_rdata),
        .load_req_o(load_req), .load_idx_o(load_idx),
        .load_wb_valid_o(load_wb_valid_o), .load_wb_rd_o(load_wb_rd_o),
        .load_wb_data_o(load_wb_data_o), .load_wb_exc_o(load_wb_exc_o),
        .load_replay_o(load_replay_o)
    );

    lsu_store_pipe u_store_pipe (
        .clk(clk), .reset_i(reset_i),
        .store_valid_i(store_valid_i), .store_base_i(store_base_i),
        .store_imm_i(store_imm_i), .store_size_i(store_size_i), .store_data_i(store_data_i),
        .store_req_o(store_req), .store_idx_o(store_idx), .store_bmask_o(store_bmask),
        .store_wdata_o(store_wdata),
        .store_wb_valid_o(store_wb_valid_o), .store_wb_exc_o(store_wb_exc_o)
    );

    lsu_mem_arbiter u_mem_arbiter (
        .load_req_i(load_req), .load_idx_i(load_idx),
        .store_req_i(store_req), .store_idx_i(store_idx),
        .store_bmask_i(store_bmask), .store_wdata_i(store_wdata),
        .load_gnt_o(load_gnt), .ram_en_o(ram_en), .ram_we_o(ram_we),
        .ram_idx_o(ram_idx), .ram_bmask_o(ram_bmask), .ram_wdata_o(ram_wdata)
    );

    lsu_data_ram u_data_ram (
        .clk(clk), .ram_en_i(ram_en), .ram_we_i(ram_we), .ram_idx_i(ram_idx),
        .ram_bmask_i(ram_bmask), .ram_wdata_i(ram_wdata), .ram_rdata_o(ram_rdata)
    );

endmodule

`default_nettype wire

//--- lsu_assert.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_assert (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    load_valid_i,
    input logic                    store_valid_i,
    input logic                    load_wb_valid_o,
    input logic                    load_replay_o,
    input lsu_op_pkg::lsu_exc_e    load_wb_exc_o,
    input lsu_mem_pkg::lsu_word_t  load_wb_data_o,
    input logic                    store_wb_valid_o
);

    int fail_count = 0;

    // a load either writes back or replays
    assert property (@(posedge clk) disable iff (reset_i)
        !(load_wb_valid_o && load_replay_o)) else begin
        $error("load writeback and replay high in the same cycle");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (load_wb_exc_o != lsu_op_pkg::EXC_NONE) |-> (load_wb_data_o == '0)) else begin
        $error("load exception reported with nonzero data");
        fail_count++;
    end

    // fixed two cycle result latency in both directions
    assert property (@(posedge clk) disable iff (reset_i)
        load_valid_i |-> ##2 (load_wb_valid_o || load_replay_o)) else begin
        $error("no load result two cycles after load_valid_i");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (load_wb_valid_o || load_replay_o) |-> $past(load_valid_i, 2)) else begin
        $error("load result without load_valid_i two cycles earlier");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        store_valid_i |-> ##2 store_wb_valid_o) else begin
        $error("no store completion two cycles after store_valid_i");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        store_wb_valid_o |-> $past(store_valid_i, 2)) else begin
        $error("store completion without store_valid_i two cycles earlier");
        fail_count++;
    end

endmodule

bind lsu_top lsu_assert u_assert (
    .clk(clk),
    .reset_i(reset_i),
    .load_valid_i(load_valid_i),
    .store_valid_i(store_valid_i),
    .load_wb_valid_o(load_wb_valid_o),
    .load_replay_o(load_replay_o),
    .load_wb_exc_o(load_wb_exc_o),
    .load_wb_data_o(load_wb_data_o),
    .store_wb_valid_o(store_wb_valid_o)
);

`default_nettype wire

//--- tb_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

    localparam lsu_op_pkg::lsu_size_e SZ_B = lsu_op_pkg::SIZE_BYTE;
    localparam lsu_op_pkg::lsu_size_e SZ_H = lsu_op_pkg::SIZE_HALF;
    localparam lsu_op_pkg::lsu_size_e SZ_W = lsu_op_pkg::SIZE_WORD;
    localparam lsu_op_pkg::lsu_exc_e EXC_N = lsu_op_pkg::EXC_NONE;
    localparam lsu_op_pkg::lsu_exc_e EXC_L = lsu_op_pkg::EXC_LOAD_MISALIGN;
    localparam lsu_op_pkg::lsu_exc_e EXC_S = lsu_op_pkg::EXC_STORE_MISALIGN;

    // expected load result kind
    localparam logic [1:0] RES_NONE = 2'd0;
    localparam logic [1:0] RES_WB = 2'd1;
    localparam logic [1:0] RES_REPLAY = 2'd2;

    typedef struct packed {
        logic                  ld_v;
        logic                  ld_late;
        logic [31:0]           ld_addr;
        lsu_op_pkg::lsu_size_e ld_size;
        logic                  ld_uext;
        logic                  st_v;
        logic [31:0]           st_addr;
        lsu_op_pkg::lsu_size_e st_size;
        logic                  st_rand;
        logic [31:0]           st_data;
        logic [1:0]            res;
        lsu_op_pkg::lsu_exc_e  ld_exc;
        lsu_op_pkg::lsu_exc_e  st_exc;
    } entry_t;

    logic                       clk;
    logic                       reset_i;
    logic                       load_valid_i;
    lsu_mem_pkg::lsu_addr_t     load_base_i;
    lsu_mem_pkg::lsu_addr_t     load_imm_i;
    lsu_op_pkg::lsu_size_e      load_size_i;
    logic                       load_uext_i;
    lsu_op_pkg::lsu_reg_t       load_rd_i;
    logic                       store_valid_i;
    lsu_mem_pkg::lsu_addr_t     store_base_i;
    lsu_mem_pkg::lsu_addr_t     store_imm_i;
    lsu_op_pkg::lsu_size_e      store_size_i;
    lsu_mem_pkg::lsu_word_t     store_data_i;
    logic                       load_wb_valid_o;
    lsu_op_pkg::lsu_reg_t       load_wb_rd_o;
    lsu_mem_pkg::lsu_word_t     load_wb_data_o;
    lsu_op_pkg::lsu_exc_e       load_wb_exc_o;
    logic                       load_replay_o;
    logic                       store_wb_valid_o;
    lsu_op_pkg::lsu_exc_e       store_wb_exc_o;

    entry_t      table_q[$];
    logic [7:0]  model_mem [0:1023];
    int          errors;

    lsu_top u_dut (.*);

    always #20 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_missing(input string name);
        $display("ERROR at %0t: expected writeback pulse did not occur on %s", $time, name);
        errors++;
    endtask

    function automatic int size_bytes(input lsu_op_pkg::lsu_size_e size);
        return (size == SZ_W) ? 4 : ((size == SZ_H) ? 2 : 1);
    endfunction

    // address must be a multiple of the access size
    function automatic logic is_aligned(input logic [31:0] addr,
                                        input lsu_op_pkg::lsu_size_e size);
        return (addr % size_bytes(size)) == 0;
    endfunction

    task automatic model_store(input logic [31:0] addr, input lsu_op_pkg::lsu_size_e size,
                               input logic [31:0] data);
        if (is_aligned(addr, size)) begin
            for (int i = 0; i < size_bytes(size); i++) begin
                model_mem[(addr + i) % 1024] = data[8*i +: 8];
            end
        end
    endtask

    // little endian gather followed by sign or zero extension
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input lsu_op_pkg::lsu_size_e size,
                                                  input logic uext);
        logic [31:0] value;
        int          n;
        n = size_bytes(size);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[8*i +: 8] = model_mem[(addr + i) % 1024];
        end
        if (!uext && n < 4 && value[8*n-1]) begin
            value = value | ~((32'd1 << (8*n)) - 32'd1);
        end
        return value;
    endfunction

    function automatic void add_entry(
        input logic                  ld_v,
        input logic                  late,
        input logic [31:0]           ld_addr,
        input lsu_op_pkg::lsu_size_e ld_size,
        input logic                  uext,
        input logic                  st_v,
        input logic [31:0]           st_addr,
        input lsu_op_pkg::lsu_size_e st_size,
        input logic                  st_rand,
        input logic [31:0]           st_data,
        input logic [1:0]            res,
        input lsu_op_pkg::lsu_exc_e  ld_exc,
        input lsu_op_pkg::lsu_exc_e  st_exc
    );
        table_q.push_back({ld_v, late, ld_addr, ld_size, uext, st_v, st_addr, st_size,
                           st_rand, st_data, res, ld_exc, st_exc});
    endfunction

    function automatic void build_table();
        // fill with random bytes
        add_entry(0, 0, 'h0, SZ_W, 0, 1, 'h100, SZ_W, 1, 'h0, RES_NONE, EXC_N, EXC_N);
        add_entry(0, 0, 'h0, SZ_W, 0, 1, 'h104, SZ_H, 1, 'h0, RES_NONE, EXC_N, EXC_N);
        add_entry(0, 0, 'h0, SZ_W, 0, 1, 'h106, SZ_B, 1, 'h0, RES_NONE, EXC_N, EXC_N);
        add_entry(0, 0, 'h0, SZ_W, 0, 1, 'h107, SZ_B, 1, 'h0, RES_NONE, EXC_N, EXC_N);
        add_entry(1, 0, 'h100, SZ_W, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h100, SZ_H, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h102, SZ_H, 1, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h100, SZ_B, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h101, SZ_B, 1, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h102, SZ_B, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h103, SZ_B, 1, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h104, SZ_W, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h104, SZ_H, 1, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        // negative byte and half values
        add_entry(0, 0, 'h0, SZ_W, 0, 1, 'h110, SZ_W, 0, 'h8001FF80, RES_NONE, EXC_N, EXC_N);
        add_entry(1, 0, 'h110, SZ_B, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h110, SZ_B, 1, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h112, SZ_H, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h112, SZ_H, 1, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        // misaligned accesses
        add_entry(1, 0, 'h101, SZ_H, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_L, EXC_N);
        add_entry(1, 0, 'h102, SZ_W, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_L, EXC_N);
        add_entry(0, 0, 'h0, SZ_W, 0, 1, 'h111, SZ_W, 0, 'hDEADBEEF, RES_NONE, EXC_N, EXC_S);
        add_entry(1, 0, 'h110, SZ_W, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        // same cycle conflicts
        add_entry(1, 0, 'h100, SZ_W, 0, 1, 'h120, SZ_W, 0, 'hCAFEF00D, RES_REPLAY, EXC_N, EXC_N);
        add_entry(1, 0, 'h120, SZ_W, 0, 0, 'h0, SZ_W, 0, 'h0, RES_WB, EXC_N, EXC_N);
        add_entry(1, 0, 'h104, SZ_W, 0, 1, 'h121, SZ_H, 0, 'h00001234, RES_WB, EXC_N, EXC_S);
        // load one cycle behind a store to the same word
        add_entry(1, 1, 'h130, SZ_W, 0, 1, 'h130, SZ_W, 0, 'h5A5AA5A5, RES_WB, EXC_N, EXC_N);
        add_entry(1, 1, 'h130, SZ_H, 0, 1, 'h131, SZ_B, 0, 'h0000009C, RES_WB, EXC_N, EXC_N);
    endfunction

    task automatic check_idle();
        compare_value("load_wb_valid_o", 1'b0, load_wb_valid_o);
        compare_value("load_replay_o", 1'b0, load_replay_o);
        compare_value("store_wb_valid_o", 1'b0, store_wb_valid_o);
    endtask

    task automatic check_load(input entry_t e, input int idx);
        logic [31:0] exp_data;
        exp_data = (e.ld_exc == EXC_N) ? expected_load(e.ld_addr, e.ld_size, e.ld_uext) : '0;
        case (e.res)
            RES_WB: begin
                if (load_wb_valid_o !== 1'b1) begin
                    report_missing("load_wb_valid_o");
                end
                compare_value("load_replay_o", 1'b0, load_replay_o);
                compare_value("load_wb_rd_o", idx[4:0], load_wb_rd_o);
                compare_value("load_wb_exc_o", e.ld_exc, load_wb_exc_o);
                compare_value("load_wb_data_o", exp_data, load_wb_data_o);
            end
            RES_REPLAY: begin
                if (load_replay_o !== 1'b1) begin
                    report_missing("load_replay_o");
                end
                compare_value("load_wb_valid_o", 1'b0, load_wb_valid_o);
            end
            default: begin
                compare_value("load_wb_valid_o", 1'b0, load_wb_valid_o);
                compare_value("load_replay_o", 1'b0, load_replay_o);
            end
        endcase
    endtask

    task automatic run_entry(input entry_t e, input int idx);
        logic [31:0] st_data;
        st_data = e.st_rand ? $urandom : e.st_data;
        @(posedge clk);
        load_valid_i  <= e.ld_v & ~e.ld_late;
        // negative immediate makes the address adder wrap
        load_base_i   <= e.ld_addr + 32'h100;
        load_imm_i    <= 32'hFFFF_FF00;
        load_size_i   <= e.ld_size;
        load_uext_i   <= e.ld_uext;
        load_rd_i     <= idx[4:0];
        store_valid_i <= e.st_v;
        store_base_i  <= e.st_addr - 32'h10;
        store_imm_i   <= 32'h10;
        store_size_i  <= e.st_size;
        store_data_i  <= st_data;
        if (e.st_v) begin
            model_store(e.st_addr, e.st_size, st_data);
        end
        @(posedge clk);
        load_valid_i  <= e.ld_v & e.ld_late;
        store_valid_i <= 1'b0;
        @(posedge clk);
        load_valid_i  <= 1'b0;
        @(negedge clk);
        if (e.st_v) begin
            if (store_wb_valid_o !== 1'b1) begin
                report_missing("store_wb_valid_o");
            end
            compare_value("store_wb_exc_o", e.st_exc, store_wb_exc_o);
        end else begin
            compare_value("store_wb_valid_o", 1'b0, store_wb_valid_o);
        end
        if (e.ld_late) begin
            @(posedge clk);
            @(negedge clk);
        end
        check_load(e, idx);
    endtask

    initial begin
        void'($urandom(24));
        errors        = 0;
        clk           = 1'b0;
        reset_i       = 1'b1;
        load_valid_i  = 1'b0;
        load_base_i   = '0;
        load_imm_i    = '0;
        load_size_i   = SZ_W;
        load_uext_i   = 1'b0;
        load_rd_i     = '0;
        store_valid_i = 1'b0;
        store_base_i  = '0;
        store_imm_i   = '0;
        store_size_i  = SZ_W;
        store_data_i  = '0;
        build_table();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) begin
                reset_i <= 1'b0;
            end
            @(negedge clk);
            check_idle();
        end
        // nothing may pulse right after reset either
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        foreach (table_q[i]) begin
            run_entry(table_q[i], i);
        end
        $display("run finished with %0d check errors and %0d assertion failures",
                 errors, u_dut.u_assert.fail_count);
        if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        @(posedge clk);
        repeat (table_q.size() * 4 + 50) @(posedge clk);
        $display("ERROR: watchdog timeout, the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
lsu_mem_pkg.sv
lsu_op_pkg.sv
lsu_load_pipe.sv
lsu_store_pipe.sv
lsu_mem_arbiter.sv
lsu_data_ram.sv
lsu_top.sv
lsu_assert.sv
tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lsu_mem_pkg.sv
      - lsu_op_pkg.sv
      - lsu_load_pipe.sv
      - lsu_store_pipe.sv
      - lsu_mem_arbiter.sv
      - lsu_data_ram.sv
      - lsu_top.sv
  - target: test
    files:
      - lsu_assert.sv
      - tb_lsu.sv
